//--- all.f
src/npc_pkg.sv
src/npc_ifu.sv
src/npc_decoder.sv
src/npc_alu.sv
src/npc_next_pc.sv
src/npc_regfile.sv
src/npc_lsu.sv
src/npc_dmem.sv
src/npc_top.sv
sim/npc_assert.sv
sim/npc_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module npc_tb -f all.f -o npc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/npc_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1

//--- sim/prog.hex
// one instruction word per line, the first one sits at pc 80000000
123450b7  // lui   x1, 0x12345
ffb00113  // addi  x2, x0, -5
67808193  // addi  x3, x1, 0x678
00312233  // slt   x4, x2, x3
003132b3  // sltu  x5, x2, x3
00400393  // addi  x7, x0, 4
80000437  // lui   x8, 0x80000
40745333  // sra   x6, x8, x7
007454b3  // srl   x9, x8, x7
40118533  // sub   x10, x3, x1
0021c5b3  // xor   x11, x3, x2
00700013  // addi  x0, x0, 7
00100633  // add   x12, x0, x1
04302023  // sw    x3, 0x40(x0)
04002683  // lw    x13, 0x40(x0)
00368463  // beq   x13, x3, +8
00100713  // addi  x14, x0, 1
00369463  // bne   x13, x3, +8
00200793  // addi  x15, x0, 2
00001817  // auipc x16, 0x1
008008ef  // jal   x17, +8
00100713  // addi  x14, x0, 1
00c88967  // jalr  x18, 12(x17)
00100713  // addi  x14, x0, 1
00100073  // ebreak

//--- sim/npc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module npc_tb;
  import npc_pkg::*;

  localparam int retire_timeout = 100;
  localparam int halt_timeout   = 100;
  localparam int quiet_cycles   = 20;

  logic    clk;
  logic    rst;
  logic    halt;
  retire_t retire;

  string   row_name [$];
  retire_t row_exp [$];  // valid is unused in the table

  npc_top dut (
    .clk    (clk),
    .rst    (rst),
    .halt   (halt),
    .retire (retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ********************
  // helpers
  // ********************

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s (%s): expected %h, actual %h", test, field, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] pc, input logic [4:0] rd,
                         input logic wen, input logic [31:0] wdata);
    retire_t r;
    r = {1'b1, pc, rd, wen, wdata};
    row_name.push_back(name);
    row_exp.push_back(r);
  endtask

  // one row per retire, values worked out by hand from the program in prog.hex
  task automatic build_table();
    add_row("lui",       32'h8000_0000, 5'd1,  1'b1, 32'h1234_5000);
    add_row("addi_neg",  32'h8000_0004, 5'd2,  1'b1, 32'hffff_fffb);
    add_row("addi",      32'h8000_0008, 5'd3,  1'b1, 32'h1234_5678);
    add_row("slt",       32'h8000_000c, 5'd4,  1'b1, 32'h0000_0001);
    add_row("sltu",      32'h8000_0010, 5'd5,  1'b1, 32'h0000_0000);
    add_row("addi_sh",   32'h8000_0014, 5'd7,  1'b1, 32'h0000_0004);
    add_row("lui_msb",   32'h8000_0018, 5'd8,  1'b1, 32'h8000_0000);
    add_row("sra",       32'h8000_001c, 5'd6,  1'b1, 32'hf800_0000);
    add_row("srl",       32'h8000_0020, 5'd9,  1'b1, 32'h0800_0000);
    add_row("sub",       32'h8000_0024, 5'd10, 1'b1, 32'h0000_0678);
    add_row("xor",       32'h8000_0028, 5'd11, 1'b1, 32'hedcb_a983);
    add_row("write_x0",  32'h8000_002c, 5'd0,  1'b1, 32'h0000_0007);
    add_row("add_x0",    32'h8000_0030, 5'd12, 1'b1, 32'h1234_5000);
    add_row("sw",        32'h8000_0034, 5'd0,  1'b0, 32'h0000_0000);
    add_row("lw",        32'h8000_0038, 5'd13, 1'b1, 32'h1234_5678);
    add_row("beq_taken", 32'h8000_003c, 5'd0,  1'b0, 32'h0000_0000);
    add_row("bne_not",   32'h8000_0044, 5'd0,  1'b0, 32'h0000_0000);
    add_row("addi_kept", 32'h8000_0048, 5'd15, 1'b1, 32'h0000_0002);
    add_row("auipc",     32'h8000_004c, 5'd16, 1'b1, 32'h8000_104c);
    add_row("jal",       32'h8000_0050, 5'd17, 1'b1, 32'h8000_0054);
    add_row("jalr",      32'h8000_0058, 5'd18, 1'b1, 32'h8000_005c);
    add_row("ebreak",    32'h8000_0060, 5'd0,  1'b0, 32'h0000_0000);
  endtask

  // retire holds for a whole cycle, so it is sampled on the falling edge
  task automatic wait_retire(output retire_t seen);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!retire.valid && cycles < retire_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!retire.valid) begin
      $display("no instruction retired within %0d cycles", retire_timeout);
      stop_with_failure();
    end
    seen = retire;
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    retire_t seen;
    int      cycles;
    rst = 1'b1;
    build_table();
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
    end
    rst <= 1'b0;

    foreach (row_exp[i]) begin
      wait_retire(seen);
      check_value(row_name[i], "pc", row_exp[i].pc, seen.pc);
      check_value(row_name[i], "reg_wen", {31'd0, row_exp[i].reg_wen}, {31'd0, seen.reg_wen});
      if (row_exp[i].reg_wen) begin  // rd and wdata only matter when a register is written
        check_value(row_name[i], "rd", {27'd0, row_exp[i].rd}, {27'd0, seen.rd});
        check_value(row_name[i], "wdata", row_exp[i].wdata, seen.wdata);
      end
    end

    cycles = 0;
    while (!halt && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("halt did not rise within %0d cycles of the last retire", halt_timeout);
      stop_with_failure();
    end

    for (int n = 0; n < quiet_cycles; n++) begin
      @(negedge clk);
      if (retire.valid) begin
        $display("an instruction retired at pc %h after halt", retire.pc);
        stop_with_failure();
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/npc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module npc_assert (
  input logic             clk,
  input logic             rst,
  input logic             halt,
  input npc_pkg::wb_m2s_t wb_m2s,
  input npc_pkg::wb_s2m_t wb_s2m
);

  // single transfers only, so cyc and stb move together
  cyc_is_stb: assert property (@(posedge clk) disable iff (rst)
    wb_m2s.cyc == wb_m2s.stb)
    else $error("wishbone cyc and stb differ");

  ack_after_stb: assert property (@(posedge clk) disable iff (rst)
    wb_s2m.ack |-> $past(wb_m2s.stb))
    else $error("wishbone ack without a strobe in the cycle before");

  req_stable: assert property (@(posedge clk) disable iff (rst)
    wb_m2s.stb && !wb_s2m.ack |=> $stable(wb_m2s.adr) && $stable(wb_m2s.we))
    else $error("wishbone adr or we changed before ack");

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt)  // only reset clears halt
    else $error("halt fell outside of reset");

endmodule

bind npc_top npc_assert u_assert (
  .clk    (clk),
  .rst    (rst),
  .halt   (halt),
  .wb_m2s (wb_m2s),
  .wb_s2m (wb_s2m)
);

`default_nettype wire

//--- src/npc_top.sv
`timescale 1ns/1ps
`default_nettype none

module npc_top (
  input  logic             clk,
  input  logic             rst,
  output logic             halt,
  output npc_pkg::retire_t retire
);
  import npc_pkg::*;

  logic [31:0] pc, npc, snpc;
  logic [31:0] inst, imm;
  ctrl_t       ctrl;
  logic [4:0]  rs1, rs2, rd;
  logic [31:0] src1, src2, reg_wdata;
  logic [31:0] alu_a, alu_b, alu_result;
  logic [31:0] mem_rdata;
  logic        stall, commit;
  wb_m2s_t     wb_m2s;
  wb_s2m_t     wb_s2m;

  // ********************
  // pc and halt
  // ********************

  assign commit = ~stall & ~halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (commit) begin
      if (ctrl.halt) begin
        halt <= 1'b1;  // pc stays on the ebreak
      end else begin
        pc <= npc;
      end
    end
  end

  // ********************
  // datapath
  // ********************

  assign alu_a = ctrl.alu_a_pc ? pc : src1;
  assign alu_b = ctrl.alu_b_imm ? imm : src2;

  always_comb begin
    case (ctrl.wb_sel)
      wb_snpc: reg_wdata = snpc;
      wb_mem:  reg_wdata = mem_rdata;
      default: reg_wdata = alu_result;
    endcase
  end

  // retire trails the commit edge by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= commit;
    end
    if (commit) begin
      retire.pc      <= pc;
      retire.rd      <= rd;
      retire.reg_wen <= ctrl.reg_wen;
      retire.wdata   <= reg_wdata;
    end
  end

  npc_ifu u_ifu (
    .clk  (clk),
    .pc   (pc),
    .inst (inst)
  );

  npc_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  npc_regfile u_regfile (
    .clk   (clk),
    .rst   (rst),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .wen   (ctrl.reg_wen & commit),
    .wdata (reg_wdata),
    .src1  (src1),
    .src2  (src2)
  );

  npc_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  npc_next_pc u_next_pc (
    .pc         (pc),
    .imm        (imm),
    .src1       (src1),
    .src2       (src2),
    .alu_result (alu_result),
    .br_op      (ctrl.br_op),
    .snpc       (snpc),
    .npc        (npc)
  );

  npc_lsu u_lsu (
    .clk   (clk),
    .rst   (rst),
    .ren   (ctrl.mem_ren),
    .wen   (ctrl.mem_wen),
    .addr  (alu_result),
    .wdata (src2),
    .rdata (mem_rdata),
    .stall (stall),
    .wb_o  (wb_m2s),
    .wb_i  (wb_s2m)
  );

  npc_dmem u_dmem (
    .clk  (clk),
    .rst  (rst),
    .wb_i (wb_m2s),
    .wb_o (wb_s2m)
  );

endmodule

`default_nettype wire

//--- src/npc_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module npc_dmem (
  input  logic             clk,
  input  logic             rst,
  input  npc_pkg::wb_m2s_t wb_i,
  output npc_pkg::wb_s2m_t wb_o
);
  import npc_pkg::*;

  logic [31:0] ram [dmem_words];
  logic [$clog2(dmem_words)-1:0] idx;
  logic        access;

  assign idx    = wb_i.adr[$clog2(dmem_words)+1:2];  // word address
  assign access = wb_i.cyc & wb_i.stb & ~wb_o.ack;

  // ack lasts one cycle, the master drops stb right after it
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_o.ack <= 1'b0;
    end else begin
      wb_o.ack <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_i.we) begin
        ram[idx] <= wb_i.dat;
      end
      wb_o.dat <= ram[idx];
    end
  end

endmodule

`default_nettype wire

//--- src/npc_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_lsu (
  input  logic              clk,
  input  logic              rst,
  input  logic              ren,
  input  logic              wen,
  input  logic [31:0]       addr,
  input  logic [31:0]       wdata,
  output logic [31:0]       rdata,
  output logic              stall,
  output npc_pkg::wb_m2s_t  wb_o,
  input  npc_pkg::wb_s2m_t  wb_i
);

  logic req;
  logic done;  // high for the cycle after ack so cyc drops between transfers

  assign req   = ren | wen;
  assign stall = req & ~wb_i.ack;  // hold the core until the slave answers
  assign rdata = wb_i.dat;

  always_comb begin
    wb_o.cyc = req & ~done;
    wb_o.stb = req & ~done;
    wb_o.we  = wen;
    wb_o.adr = addr;
    wb_o.dat = wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= wb_i.ack;
    end
  end

endmodule

`default_nettype wire

//--- src/npc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module npc_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] src1,
  output logic [31:0] src2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
  assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/npc_next_pc.sv
`timescale 1ns/1ps
`default_nettype none

module npc_next_pc (
  input  logic [31:0]     pc,
  input  logic [31:0]     imm,
  input  logic [31:0]     src1,
  input  logic [31:0]     src2,
  input  logic [31:0]     alu_result,
  input  npc_pkg::br_op_e br_op,
  output logic [31:0]     snpc,
  output logic [31:0]     npc
);
  import npc_pkg::*;

  logic [31:0] dnpc;
  logic        taken;

  assign snpc = pc + 32'd4;
  assign dnpc = pc + imm;

  always_comb begin
    case (br_op)
      br_beq:  taken = (src1 == src2);
      br_bne:  taken = (src1 != src2);
      br_blt:  taken = $signed(src1) < $signed(src2);
      br_bge:  taken = $signed(src1) >= $signed(src2);
      br_bltu: taken = src1 < src2;
      br_bgeu: taken = src1 >= src2;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (br_op)
      br_seq:  npc = snpc;
      br_jal:  npc = dnpc;
      br_jalr: npc = {alu_result[31:1], 1'b0};
      default: npc = taken ? dnpc : snpc;  // conditional branches
    endcase
  end

endmodule

`default_nettype wire

//--- src/npc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_alu (
  input  npc_pkg::alu_op_e op,
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  output logic [31:0]      result
);
  import npc_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu:   result = {31'b0, a < b};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);  // sign fill
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;  // lui
      default:    result = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- src/npc_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module npc_decoder (
  input  logic [31:0]    inst,
  output npc_pkg::ctrl_t ctrl,
  output logic [31:0]    imm,
  output logic [4:0]     rs1,
  output logic [4:0]     rs2,
  output logic [4:0]     rd
);
  import npc_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic        funct7_5;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode   = opcode_e'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign funct7_5 = inst[30];
  assign rs1      = inst[19:15];
  assign rs2      = inst[24:20];
  assign rd       = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.br_op  = br_seq;
    ctrl.wb_sel = wb_alu;
    imm         = imm_i;
    case (opcode)
      op_lui: begin
        imm = imm_u;
        ctrl.alu_op = alu_pass_b;
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
      end
      op_auipc: begin
        imm = imm_u;
        ctrl.alu_a_pc = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
      end
      op_jal: begin
        imm = imm_j;
        ctrl.br_op = br_jal;
        ctrl.wb_sel = wb_snpc;  // link value
        ctrl.reg_wen = 1'b1;
      end
      op_jalr: begin
        ctrl.br_op = br_jalr;
        ctrl.alu_b_imm = 1'b1;  // the alu forms rs1 + imm
        ctrl.wb_sel = wb_snpc;
        ctrl.reg_wen = 1'b1;
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000:  ctrl.br_op = br_beq;
          3'b001:  ctrl.br_op = br_bne;
          3'b100:  ctrl.br_op = br_blt;
          3'b101:  ctrl.br_op = br_bge;
          3'b110:  ctrl.br_op = br_bltu;
          3'b111:  ctrl.br_op = br_bgeu;
          default: ctrl.halt = 1'b1;
        endcase
      end
      op_load: begin
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_sel = wb_mem;
        ctrl.mem_ren = (funct3 == 3'b010);  // only lw
        ctrl.reg_wen = (funct3 == 3'b010);
        ctrl.halt = (funct3 != 3'b010);
      end
      op_store: begin
        imm = imm_s;
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_wen = (funct3 == 3'b010);
        ctrl.halt = (funct3 != 3'b010);
      end
      op_imm: begin
        // srai is the only immediate op where bit 30 selects the variant
        ctrl.alu_op = alu_decode(funct3, funct7_5 && (funct3 == 3'b101));
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
      end
      op_reg: begin
        ctrl.alu_op = alu_decode(funct3, funct7_5);
        ctrl.reg_wen = 1'b1;
      end
      op_system: ctrl.halt = 1'b1;  // ebreak, and ecall stops the core as well
      default:   ctrl.halt = 1'b1;  // unknown opcode shows up as a halt
    endcase
  end

endmodule

`default_nettype wire

//--- src/npc_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_ifu (
  input  logic        clk,
  input  logic [31:0] pc,
  output logic [31:0] inst
);
  import npc_pkg::*;

  logic [31:0] rom [imem_words];
  logic [31:0] offset;

  initial begin
    $readmemh("sim/prog.hex", rom);
  end

  assign offset = pc - reset_pc;  // the program is linked at reset_pc
  assign inst = rom[offset[$clog2(imem_words)+1:2]];

endmodule

`default_nettype wire

//--- src/npc_pkg.sv
`default_nettype none

package npc_pkg;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam int imem_words = 64;
  localparam int dmem_words = 64;

  // ********************
  // encodings
  // ********************

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // nine modes, so this one needs a fourth bit
  typedef enum logic [3:0] {
    br_seq, br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } br_op_e;

  typedef enum logic [1:0] {
    wb_alu, wb_snpc, wb_mem
  } wb_sel_e;

  // ********************
  // bundles
  // ********************

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_b_imm;
    logic    alu_a_pc;  // auipc takes the pc as operand a
    br_op_e  br_op;
    wb_sel_e wb_sel;
    logic    reg_wen;
    logic    mem_ren;
    logic    mem_wen;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        reg_wen;
    logic [31:0] wdata;
  } retire_t;

endpackage

`default_nettype wire
